// File: verilog/fp_mac_cfg.svh
`ifndef FP_MAC_CFG_SVH
`define FP_MAC_CFG_SVH

// single precision layout
`define FP_W         32
`define FP_EXP_W     8
`define FP_FRAC_W    23
`define FP_BIAS      127
`define FP_EXP_MAX   255

`define FP_QNAN      32'h7FC0_0000  // canonical quiet nan

`define APB_ADDR_W   8

`define REG_ALPHA    8'h00
`define REG_BRAVO    8'h04
`define REG_ACC      8'h08
`define REG_CTRL     8'h0C
`define REG_STATUS   8'h10  // read only
`define REG_RESULT   8'h14  // read only

`define OP_MUL       2'd0
`define OP_ADD       2'd1
`define OP_MAC       2'd2
`define CTRL_ACC_BIT 2      // mac result also written to acc

`endif

// File: verilog/fp_mac_pkg.sv
`include "fp_mac_cfg.svh"

package fp_mac_pkg;

    typedef struct packed {
        logic                  sign;
        logic [`FP_EXP_W-1:0]  exp;   // biased
        logic [`FP_FRAC_W-1:0] frac;  // hidden bit not stored
    } fp32_fields_t;

    // bus word and float fields share the same 32 bits
    typedef union packed {
        logic [`FP_W-1:0] word;
        fp32_fields_t     fld;
    } fp32_u;

endpackage

// File: verilog/fp_round.sv
`timescale 1ns/1ps
`include "fp_mac_cfg.svh"

module fp_round
    import fp_mac_pkg::*;
(
    input  logic                  sign,
    input  logic signed [9:0]     exp_in,
    input  logic [`FP_FRAC_W:0]   sig_in,
    input  logic                  guard,
    input  logic                  round_bit,
    input  logic                  sticky,
    output fp32_u                 result
);
    localparam int SIG_W = `FP_FRAC_W + 1;
    localparam logic signed [9:0] EXP_MAX = `FP_EXP_MAX;

    logic                    round_up;
    logic [SIG_W:0]          sig_rnd;
    logic [`FP_FRAC_W-1:0]   frac_out;
    logic signed [9:0]       exp_adj;

    // nearest, ties to even
    assign round_up = guard & (round_bit | sticky | sig_in[0]);
    assign sig_rnd  = {1'b0, sig_in} + {{SIG_W{1'b0}}, round_up};

    always_comb begin
        if (sig_rnd[SIG_W]) begin  // carry out of rounding
            frac_out = sig_rnd[SIG_W-1:1];
            exp_adj  = exp_in + 10'sd1;
        end else begin
            frac_out = sig_rnd[SIG_W-2:0];
            exp_adj  = exp_in;
        end
    end

    always_comb begin
        if (exp_adj >= EXP_MAX) begin
            result.word = {sign, {`FP_EXP_W{1'b1}}, {`FP_FRAC_W{1'b0}}};  // inf
        end else if (exp_adj <= 10'sd0) begin
            result.word = {sign, {(`FP_W-1){1'b0}}};  // flush to zero
        end else begin
            result.fld.sign = sign;
            result.fld.exp  = exp_adj[`FP_EXP_W-1:0];
            result.fld.frac = frac_out;
        end
    end

endmodule

// File: verilog/fp_mul.sv
`timescale 1ns/1ps
`include "fp_mac_cfg.svh"

module fp_mul
    import fp_mac_pkg::*;
(
    input  fp32_u a,
    input  fp32_u b,
    output fp32_u product
);
    localparam int SIG_W = `FP_FRAC_W + 1;
    localparam logic signed [9:0] BIAS = `FP_BIAS;

    logic                   a_nan, b_nan;
    logic                   a_inf, b_inf;
    logic                   a_zero, b_zero;
    logic                   sign;
    logic [SIG_W-1:0]       sig_a, sig_b;
    logic [2*SIG_W-1:0]     sig_prod;
    logic [SIG_W-1:0]       sig_norm;
    logic                   guard, round_bit, sticky;
    logic                   norm_shift;
    logic signed [9:0]      exp_sum;
    fp32_u                  rounded;

    assign a_nan  = (a.fld.exp == `FP_EXP_MAX) && (a.fld.frac != '0);
    assign b_nan  = (b.fld.exp == `FP_EXP_MAX) && (b.fld.frac != '0);
    assign a_inf  = (a.fld.exp == `FP_EXP_MAX) && (a.fld.frac == '0);
    assign b_inf  = (b.fld.exp == `FP_EXP_MAX) && (b.fld.frac == '0);
    assign a_zero = a.fld.exp == '0;  // subnormals read as zero
    assign b_zero = b.fld.exp == '0;

    assign sign  = a.fld.sign ^ b.fld.sign;
    assign sig_a = {1'b1, a.fld.frac};
    assign sig_b = {1'b1, b.fld.frac};

    assign sig_prod   = sig_a * sig_b;
    assign norm_shift = sig_prod[2*SIG_W-1];  // product in [2,4)

    always_comb begin
        if (norm_shift) begin
            sig_norm  = sig_prod[2*SIG_W-1 -: SIG_W];
            guard     = sig_prod[SIG_W-1];
            round_bit = sig_prod[SIG_W-2];
            sticky    = |sig_prod[SIG_W-3:0];
        end else begin
            sig_norm  = sig_prod[2*SIG_W-2 -: SIG_W];
            guard     = sig_prod[SIG_W-2];
            round_bit = sig_prod[SIG_W-3];
            sticky    = |sig_prod[SIG_W-4:0];
        end
    end

    assign exp_sum = {2'b00, a.fld.exp} + {2'b00, b.fld.exp} - BIAS + {9'd0, norm_shift};

    fp_round fp_round_i (
        .sign      (sign),
        .exp_in    (exp_sum),
        .sig_in    (sig_norm),
        .guard     (guard),
        .round_bit (round_bit),
        .sticky    (sticky),
        .result    (rounded)
    );

    always_comb begin
        if (a_nan || b_nan || (a_inf && b_zero) || (b_inf && a_zero)) begin
            product.word = `FP_QNAN;
        end else if (a_inf || b_inf) begin
            product.word = {sign, {`FP_EXP_W{1'b1}}, {`FP_FRAC_W{1'b0}}};
        end else if (a_zero || b_zero) begin
            product.word = {sign, {(`FP_W-1){1'b0}}};
        end else begin
            product = rounded;
        end
    end

endmodule

// File: verilog/fp_add.sv
`timescale 1ns/1ps
`include "fp_mac_cfg.svh"

module fp_add
    import fp_mac_pkg::*;
(
    input  fp32_u a,
    input  fp32_u b,
    output fp32_u sum
);
    localparam int SIG_W = `FP_FRAC_W + 1;
    localparam int ALN_W = SIG_W + 2;  // significand plus guard and round

    logic                   a_nan, b_nan;
    logic                   a_inf, b_inf;
    logic                   a_zero, b_zero;
    logic                   swap;
    logic                   subtract;
    fp32_u                  big, little;
    logic [`FP_EXP_W-1:0]   exp_diff;
    logic [4:0]             shamt;
    logic [SIG_W-1:0]       sig_big, sig_little;
    logic [SIG_W+ALN_W-1:0] wide;
    logic [ALN_W:0]         op_big, op_little;
    logic [ALN_W+1:0]       raw;
    logic [4:0]             lz;
    logic [ALN_W:0]         shifted;
    logic [SIG_W-1:0]       sig_norm;
    logic                   guard, round_bit, sticky;
    logic signed [9:0]      exp_norm;
    fp32_u                  rounded;

    assign a_nan  = (a.fld.exp == `FP_EXP_MAX) && (a.fld.frac != '0);
    assign b_nan  = (b.fld.exp == `FP_EXP_MAX) && (b.fld.frac != '0);
    assign a_inf  = (a.fld.exp == `FP_EXP_MAX) && (a.fld.frac == '0);
    assign b_inf  = (b.fld.exp == `FP_EXP_MAX) && (b.fld.frac == '0);
    assign a_zero = a.fld.exp == '0;
    assign b_zero = b.fld.exp == '0;

    // larger magnitude goes first
    assign swap     = b.word[`FP_W-2:0] > a.word[`FP_W-2:0];
    assign big      = swap ? b : a;
    assign little   = swap ? a : b;
    assign subtract = big.fld.sign ^ little.fld.sign;

    assign exp_diff   = big.fld.exp - little.fld.exp;
    assign shamt      = (exp_diff > 8'd26) ? 5'd26 : exp_diff[4:0];
    assign sig_big    = {1'b1, big.fld.frac};
    assign sig_little = {1'b1, little.fld.frac};

    // everything below round folds into sticky
    assign wide      = {sig_little, {ALN_W{1'b0}}} >> shamt;
    assign op_little = {wide[SIG_W+ALN_W-1 -: ALN_W], |wide[SIG_W-1:0]};
    assign op_big    = {sig_big, 3'b000};

    assign raw = subtract ? {1'b0, op_big} - {1'b0, op_little}
                          : {1'b0, op_big} + {1'b0, op_little};

    always_comb begin
        lz = '0;
        for (int i = 0; i <= ALN_W; i++) begin
            if (raw[i]) begin
                lz = 5'(ALN_W - i);  // highest set bit wins
            end
        end
    end

    always_comb begin
        shifted = raw[ALN_W:0] << lz;
        if (raw[ALN_W+1]) begin  // carry out
            sig_norm  = raw[ALN_W+1 -: SIG_W];
            guard     = raw[3];
            round_bit = raw[2];
            sticky    = raw[1] | raw[0];
            exp_norm  = {2'b00, big.fld.exp} + 10'sd1;
        end else begin
            sig_norm  = shifted[ALN_W -: SIG_W];
            guard     = shifted[2];
            round_bit = shifted[1];
            sticky    = shifted[0];
            exp_norm  = {2'b00, big.fld.exp} - {5'd0, lz};
        end
    end

    fp_round fp_round_i (
        .sign      (big.fld.sign),
        .exp_in    (exp_norm),
        .sig_in    (sig_norm),
        .guard     (guard),
        .round_bit (round_bit),
        .sticky    (sticky),
        .result    (rounded)
    );

    always_comb begin
        if (a_nan || b_nan || (a_inf && b_inf && (a.fld.sign != b.fld.sign))) begin
            sum.word = `FP_QNAN;
        end else if (a_inf) begin
            sum = a;
        end else if (b_inf) begin
            sum = b;
        end else if (a_zero && b_zero) begin
            sum.word = {a.fld.sign & b.fld.sign, {(`FP_W-1){1'b0}}};
        end else if (a_zero) begin
            sum = b;
        end else if (b_zero) begin
            sum = a;
        end else if (raw == '0) begin
            sum.word = '0;  // exact cancellation is +0
        end else begin
            sum = rounded;
        end
    end

endmodule

// File: verilog/fp_mac_unit.sv
`timescale 1ns/1ps
`include "fp_mac_cfg.svh"

module fp_mac_unit
    import fp_mac_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  logic [1:0] op,
    input  fp32_u      alpha,
    input  fp32_u      bravo,
    input  fp32_u      acc,
    output fp32_u      result,
    output logic       result_valid
);
    fp32_u      prod;
    fp32_u      sum;
    fp32_u      s1_lhs;
    fp32_u      s1_rhs;
    logic [1:0] s1_op;
    logic       s1_valid;

    fp_mul fp_mul_i (
        .a       (alpha),
        .b       (bravo),
        .product (prod)
    );

    fp_add fp_add_i (
        .a   (s1_lhs),
        .b   (s1_rhs),
        .sum (sum)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid     <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            s1_valid     <= start;
            result_valid <= s1_valid;
        end
    end

    // stage 1 product, stage 2 sum
    always_ff @(posedge clk) begin
        if (start) begin
            s1_op  <= op;
            s1_lhs <= (op == `OP_ADD) ? alpha : prod;
            s1_rhs <= (op == `OP_ADD) ? bravo : acc;
        end
        if (s1_valid) begin
            result <= (s1_op == `OP_MUL) ? s1_lhs : sum;  // mul skips the adder
        end
    end

endmodule

// File: verilog/fp_mac_apb.sv
`timescale 1ns/1ps
`include "fp_mac_cfg.svh"

module fp_mac_apb (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`APB_ADDR_W-1:0] paddr,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`FP_W-1:0]       pwdata,
    output logic [`FP_W-1:0]       prdata,
    output logic                   pready,
    output logic                   pslverr
);
    logic [`FP_W-1:0] alpha_q;
    logic [`FP_W-1:0] bravo_q;
    logic [`FP_W-1:0] acc_q;
    logic [`FP_W-1:0] result_q;
    logic [1:0]       ctrl_op_q;
    logic             ctrl_acc_q;
    logic             busy;
    logic             done;
    logic             setup;
    logic             access;
    logic             addr_hit;
    logic             bad;
    logic             wr_en;
    logic             start;
    logic [`FP_W-1:0] rd_mux;
    logic [`FP_W-1:0] unit_result;
    logic             unit_valid;

    assign pready = 1'b1;  // no wait states
    assign setup  = psel & ~penable;
    assign access = psel & penable;

    always_comb begin
        addr_hit = 1'b1;
        rd_mux   = '0;
        case (paddr)
            `REG_ALPHA:  rd_mux = alpha_q;
            `REG_BRAVO:  rd_mux = bravo_q;
            `REG_ACC:    rd_mux = acc_q;
            `REG_CTRL:   rd_mux = {{(`FP_W-3){1'b0}}, ctrl_acc_q, ctrl_op_q};
            `REG_STATUS: rd_mux = {{(`FP_W-2){1'b0}}, done, busy};
            `REG_RESULT: rd_mux = result_q;
            default:     addr_hit = 1'b0;
        endcase
    end

    assign bad = ~addr_hit | (pwrite & (paddr == `REG_CTRL) & busy);

    // decided in setup, presented in access
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prdata  <= '0;
            pslverr <= 1'b0;
        end else begin
            pslverr <= setup & bad;
            if (setup) begin
                prdata <= pwrite ? '0 : rd_mux;
            end
        end
    end

    assign wr_en = access & pwrite & ~pslverr;
    assign start = wr_en & (paddr == `REG_CTRL);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alpha_q    <= '0;
            bravo_q    <= '0;
            acc_q      <= '0;
            result_q   <= '0;
            ctrl_op_q  <= `OP_MUL;
            ctrl_acc_q <= 1'b0;
            busy       <= 1'b0;
            done       <= 1'b0;
        end else begin
            if (wr_en) begin
                case (paddr)
                    `REG_ALPHA: alpha_q <= pwdata;
                    `REG_BRAVO: bravo_q <= pwdata;
                    `REG_ACC:   acc_q   <= pwdata;
                    `REG_CTRL: begin
                        ctrl_op_q  <= pwdata[1:0];
                        ctrl_acc_q <= pwdata[`CTRL_ACC_BIT];
                    end
                    default: ;  // status and result ignore writes
                endcase
            end
            if (start) begin
                busy <= 1'b1;
                done <= 1'b0;
            end
            if (unit_valid) begin
                busy     <= 1'b0;
                done     <= 1'b1;
                result_q <= unit_result;
                if (ctrl_op_q == `OP_MAC && ctrl_acc_q) begin
                    acc_q <= unit_result;  // chain dot product
                end
            end
        end
    end

    fp_mac_unit fp_mac_unit_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .op           (pwdata[1:0]),  // sampled with start
        .alpha        (alpha_q),
        .bravo        (bravo_q),
        .acc          (acc_q),
        .result       (unit_result),
        .result_valid (unit_valid)
    );

endmodule

// File: verif/fp_mac_tb.sv
`timescale 1ns/1ps
`include "fp_mac_cfg.svh"

module fp_mac_tb;
    localparam int N_MUL = 200;
    localparam int N_ADD = 200;
    localparam int N_DOT = 16;
    localparam int N_OPS = N_MUL + N_ADD + N_DOT + 16;
    localparam int N_XFER = N_OPS * 7 + 40;         // writes, polls and result read per op
    localparam int TIMEOUT_NS = N_XFER * 3 * 100 + 20000;  // 3 cycles per transfer

    logic                   clk;
    logic                   rst_n;
    logic [`APB_ADDR_W-1:0] paddr;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`FP_W-1:0]       pwdata;
    logic [`FP_W-1:0]       prdata;
    logic                   pready;
    logic                   pslverr;

    integer seed = 38;
    int     err_count = 0;
    int     pass_count = 0;
    int     fail_count = 0;

    fp_mac_apb fp_mac_apb_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: run did not finish within %0d ns", TIMEOUT_NS);
        $display("TEST FAILED");
        $finish;
    end

    task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else begin
            $display("FAIL %0t: %s got %08h expected %08h", $time, what, got, exp);
            err_count++;
        end
    endtask

    // setup, access, then one idle cycle
    task automatic bus_transfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                                output logic [31:0] rdata, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);  // access phase settled
        rdata = prdata;
        err   = pslverr;
        check_word("pready", {31'd0, pready}, 32'd1);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        logic        err;
        bus_transfer(1'b1, addr, data, unused, err);
        check_word("pslverr on write", {31'd0, err}, 32'd0);
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
        logic err;
        bus_transfer(1'b0, addr, '0, data, err);
        check_word("pslverr on read", {31'd0, err}, 32'd0);
    endtask

    task automatic wait_done();
        logic [31:0] status;
        int          polls;
        polls  = 0;
        status = '0;
        while (status[1] == 1'b0 && polls < 8) begin
            read_reg(`REG_STATUS, status);
            polls++;
        end
        if (status[1] == 1'b0) begin
            $display("done flag never set after CTRL write at %0t", $time);
            err_count++;
        end else begin
            check_word("status after done", status, 32'h2);  // done, not busy
        end
    endtask

    task automatic run_op(input logic [1:0] op, input logic acc_en, input logic [31:0] a,
                          input logic [31:0] b, output logic [31:0] res);
        write_reg(`REG_ALPHA, a);
        write_reg(`REG_BRAVO, b);
        write_reg(`REG_CTRL, {29'd0, acc_en, op});
        wait_done();
        read_reg(`REG_RESULT, res);
    endtask

    task automatic finish_test(input string name, input int start_errs);
        if (err_count == start_errs) begin
            pass_count++;
            $display("%s: pass", name);
        end else begin
            fail_count++;
            $display("%s: fail, %0d errors", name, err_count - start_errs);
        end
    endtask

    // exponent zero reads as signed zero
    function automatic real to_real(input logic [31:0] w);
        logic [63:0] d;
        if (w[30:23] == 8'd0) begin
            d = {w[31], 63'd0};
        end else if (w[30:23] == 8'hFF) begin
            d = {w[31], 11'h7FF, w[22:0], 29'd0};
        end else begin
            d = {w[31], 11'(w[30:23] + 11'd896), w[22:0], 29'd0};
        end
        return $bitstoreal(d);
    endfunction

    // nearest even rounding with flush below normal range
    function automatic logic [31:0] to_single(input real r);
        logic [63:0] d;
        logic [24:0] sig;
        logic [28:0] rest;
        int          e;
        d = $realtobits(r);
        if (d[62:52] == 11'h7FF) begin
            return (d[51:0] != '0) ? `FP_QNAN : {d[63], 8'hFF, 23'd0};
        end
        if (d[62:52] == 11'd0) begin
            return {d[63], 31'd0};
        end
        e    = int'(d[62:52]) - 896;
        sig  = {2'b01, d[51:29]};
        rest = d[28:0];
        if (rest[28] && (rest[27:0] != '0 || sig[0])) begin
            sig = sig + 25'd1;
        end
        if (sig[24]) begin
            sig = sig >> 1;
            e   = e + 1;
        end
        if (e >= 255) begin
            return {d[63], 8'hFF, 23'd0};
        end
        if (e <= 0) begin
            return {d[63], 31'd0};
        end
        return {d[63], 8'(e), sig[22:0]};
    endfunction

    function automatic logic [31:0] rand_operand();
        logic [31:0] r;
        logic [31:0] f;
        logic [7:0]  e;
        r = $random(seed);
        f = $random(seed);
        e = 8'd64 + 8'(r[15:0] % 16'd127);  // 64 to 190
        return {r[31], e, f[22:0]};
    endfunction

    task automatic run_special(input string name, input logic [1:0] op, input logic [31:0] a,
                               input logic [31:0] b, input logic [31:0] exp);
        logic [31:0] res;
        run_op(op, 1'b0, a, b, res);
        check_word(name, res, exp);
    endtask

    initial begin
        logic [31:0] a, b, res, acc_m, data;
        logic        err;
        int          start_errs;
        rst_n   <= 1'b0;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= '0;
        pwdata  <= '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        start_errs = err_count;
        check_word("pslverr after reset", {31'd0, pslverr}, 32'd0);
        read_reg(`REG_STATUS, data);
        check_word("status after reset", data, 32'd0);
        read_reg(`REG_RESULT, data);
        check_word("result after reset", data, 32'd0);
        finish_test("reset", start_errs);

        start_errs = err_count;
        for (int i = 0; i < N_MUL; i++) begin
            a = rand_operand();
            b = rand_operand();
            run_op(`OP_MUL, 1'b0, a, b, res);
            check_word("mul result", res, to_single(to_real(a) * to_real(b)));
        end
        finish_test("multiply", start_errs);

        start_errs = err_count;
        for (int i = 0; i < N_ADD; i++) begin
            a = rand_operand();
            b = rand_operand();
            if (i % 4 == 0) begin
                b = {~a[31], a[30:0]};  // exact cancellation
            end else if (i % 4 == 1) begin
                b = {~a[31], a[30:8], b[7:0]};  // near cancellation
            end
            run_op(`OP_ADD, 1'b0, a, b, res);
            check_word("add result", res, to_single(to_real(a) + to_real(b)));
            if (i % 4 == 0) begin
                check_word("cancel result", res, 32'h0);
            end
        end
        finish_test("add", start_errs);

        start_errs = err_count;
        acc_m = '0;
        write_reg(`REG_ACC, acc_m);
        for (int i = 0; i < N_DOT; i++) begin
            a = rand_operand();
            b = rand_operand();
            acc_m = to_single(to_real(to_single(to_real(a) * to_real(b))) + to_real(acc_m));
            run_op(`OP_MAC, 1'b1, a, b, res);
            check_word("mac step result", res, acc_m);
        end
        read_reg(`REG_ACC, data);
        check_word("acc after dot product", data, acc_m);
        finish_test("mac accumulate", start_errs);

        start_errs = err_count;
        run_special("nan times one", `OP_MUL, 32'h7FC0_0001, 32'h3F80_0000, `FP_QNAN);
        run_special("one plus nan", `OP_ADD, 32'h3F80_0000, 32'hFF80_0123, `FP_QNAN);
        run_special("inf times zero", `OP_MUL, 32'h7F80_0000, 32'h0000_0000, `FP_QNAN);
        run_special("inf plus -inf", `OP_ADD, 32'h7F80_0000, 32'hFF80_0000, `FP_QNAN);
        run_special("overflow to inf", `OP_MUL, 32'h7F00_0000, 32'h4080_0000, 32'h7F80_0000);
        run_special("underflow to -0", `OP_MUL, 32'h0D80_0000, 32'h8D80_0000, 32'h8000_0000);
        run_special("exp zero times two", `OP_MUL, 32'h0040_0000, 32'h4000_0000, 32'h0);
        run_special("exp zero plus one", `OP_ADD, 32'h0040_0000, 32'h3F80_0000, 32'h3F80_0000);
        finish_test("special cases", start_errs);

        start_errs = err_count;
        write_reg(`REG_ALPHA, 32'h4000_0000);  // 2.0
        write_reg(`REG_BRAVO, 32'h4040_0000);  // 3.0
        bus_transfer(1'b1, `REG_CTRL, {30'd0, `OP_MUL}, data, err);
        check_word("pslverr on first ctrl", {31'd0, err}, 32'd0);
        bus_transfer(1'b1, `REG_CTRL, {30'd0, `OP_ADD}, data, err);
        check_word("pslverr on ctrl while busy", {31'd0, err}, 32'd1);
        wait_done();
        read_reg(`REG_RESULT, data);
        check_word("result after rejected ctrl", data, 32'h40C0_0000);
        bus_transfer(1'b0, 8'h18, '0, data, err);
        check_word("pslverr on unmapped read", {31'd0, err}, 32'd1);
        bus_transfer(1'b1, 8'h20, 32'h1234_5678, data, err);
        check_word("pslverr on unmapped write", {31'd0, err}, 32'd1);
        write_reg(`REG_RESULT, 32'h1234_5678);  // read only register ignores the write
        read_reg(`REG_RESULT, data);
        check_word("result after bus errors", data, 32'h40C0_0000);
        read_reg(`REG_STATUS, data);
        check_word("status after bus errors", data, 32'h2);
        finish_test("bus errors", start_errs);

        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+verilog
verilog/fp_mac_pkg.sv
verilog/fp_round.sv
verilog/fp_mul.sv
verilog/fp_add.sv
verilog/fp_mac_unit.sv
verilog/fp_mac_apb.sv
verif/fp_mac_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the fp_mac testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module fp_mac_tb -o fp_mac_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/fp_mac_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST OK$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
